// ==== hdl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	localparam int XLEN    = 32;
	localparam int REG_AW  = 5;
	localparam int WEN_W   = XLEN / 8;	// one write enable per byte lane
	localparam int BOFF_W  = 2;
	localparam int SHAMT_W = 5;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_AND  = 4'd2,
		ALU_OR   = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_NOR  = 4'd5,
		ALU_SLT  = 4'd6,
		ALU_SLTU = 4'd7,
		ALU_SLL  = 4'd8,	// shifts take the amount from opr1
		ALU_SRL  = 4'd9,
		ALU_SRA  = 4'd10,
		ALU_LUI  = 4'd11
	} alu_op_e;

	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LBU  = 4'd2,
		MEM_LH   = 4'd3,
		MEM_LHU  = 4'd4,
		MEM_LW   = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} mem_op_e;

	// decoded instruction entering execute
	typedef struct packed {
		logic [XLEN-1:0]   inst;
		logic              inslot;	// branch delay slot
		logic [XLEN-1:0]   pc;
		logic [XLEN-1:0]   opr1;
		logic [XLEN-1:0]   opr2;
		logic [XLEN-1:0]   offset;	// load/store displacement
		logic              wren;
		logic [REG_AW-1:0] waddr;
		logic              nofwd;
		alu_op_e           aluop;
		mem_op_e           memop;
	} ex_in_t;

	// stage register toward mem
	typedef struct packed {
		logic              wren;
		logic [REG_AW-1:0] waddr;
		logic [XLEN-1:0]   wdata;
		logic              nofwd;
		logic [XLEN-1:0]   inst;
		logic              inslot;
		logic [XLEN-1:0]   pc;
		mem_op_e           memop;
		logic [BOFF_W-1:0] boff;	// needed by mem for load alignment
	} ex_out_t;

	typedef struct packed {
		logic              en;
		logic [WEN_W-1:0]  wen;
		logic [XLEN-1:0]   addr;
		logic [XLEN-1:0]   wdata;
	} dmem_req_t;

	// bubble, what flush and reset leave in the register
	localparam ex_out_t EX_OUT_EMPTY = '{
		wren:   1'b0,
		waddr:  '0,
		wdata:  '0,
		nofwd:  1'b0,
		inst:   '0,
		inslot: 1'b0,
		pc:     '0,
		memop:  MEM_NONE,
		boff:   '0
	};

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::alu_op_e     aluop_i,
	input  wire [cpu_pkg::XLEN-1:0]   opr1_i,
	input  wire [cpu_pkg::XLEN-1:0]   opr2_i,
	output logic [cpu_pkg::XLEN-1:0]  res_o
);
	import cpu_pkg::*;

	logic [XLEN-1:0]    sum;
	logic [XLEN-1:0]    diff;
	logic [XLEN-1:0]    and_res;
	logic [XLEN-1:0]    or_res;
	logic [XLEN-1:0]    xor_res;
	logic               s_opr1;
	logic               s_opr2;
	logic               lt_s;
	logic               lt_u;
	logic [SHAMT_W-1:0] shamt;
	logic [XLEN-1:0]    sll_res;
	logic [XLEN-1:0]    srl_res;
	logic [XLEN-1:0]    sra_res;
	logic [XLEN-1:0]    lui_res;

	assign sum     = opr1_i + opr2_i;
	assign diff    = opr1_i - opr2_i;
	assign and_res = opr1_i & opr2_i;
	assign or_res  = opr1_i | opr2_i;
	assign xor_res = opr1_i ^ opr2_i;

	// signed compare
	// differing signs decide at once, else the difference sign does
	assign s_opr1 = opr1_i[XLEN-1];
	assign s_opr2 = opr2_i[XLEN-1];
	assign lt_s   = (s_opr1 != s_opr2) ? s_opr1 : diff[XLEN-1];
	assign lt_u   = opr1_i < opr2_i;

	assign shamt   = opr1_i[SHAMT_W-1:0];	// sa field or rs low bits
	assign sll_res = opr2_i << shamt;
	assign srl_res = opr2_i >> shamt;
	assign sra_res = $unsigned($signed(opr2_i) >>> shamt);
	assign lui_res = {opr2_i[XLEN/2-1:0], {(XLEN/2){1'b0}}};

	always_comb begin
		case (aluop_i)
			ALU_ADD: begin
				res_o = sum;	// no overflow trap
			end
			ALU_SUB: begin
				res_o = diff;
			end
			ALU_AND: begin
				res_o = and_res;
			end
			ALU_OR: begin
				res_o = or_res;
			end
			ALU_XOR: begin
				res_o = xor_res;
			end
			ALU_NOR: begin
				res_o = ~or_res;
			end
			ALU_SLT: begin
				res_o = {{(XLEN-1){1'b0}}, lt_s};
			end
			ALU_SLTU: begin
				res_o = {{(XLEN-1){1'b0}}, lt_u};
			end
			ALU_SLL: begin
				res_o = sll_res;
			end
			ALU_SRL: begin
				res_o = srl_res;
			end
			ALU_SRA: begin
				res_o = sra_res;
			end
			ALU_LUI: begin
				res_o = lui_res;
			end
			default: begin
				res_o = '0;	// unused encodings
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/mem_access.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_access (
	input  wire cpu_pkg::mem_op_e           memop_i,
	input  wire [cpu_pkg::XLEN-1:0]         base_i,
	input  wire [cpu_pkg::XLEN-1:0]         offset_i,
	input  wire [cpu_pkg::XLEN-1:0]         store_i,
	input  wire                             kill_i,
	output cpu_pkg::dmem_req_t              req_o,
	output logic [cpu_pkg::BOFF_W-1:0]      boff_o
);
	import cpu_pkg::*;

	logic [XLEN-1:0]   addr;
	logic              is_load;
	logic              is_store;
	logic [WEN_W-1:0]  wen;
	logic [XLEN-1:0]   wdata;

	assign addr   = base_i + offset_i;
	assign boff_o = addr[BOFF_W-1:0];

	always_comb begin
		is_load  = 1'b0;
		is_store = 1'b0;
		wen      = '0;
		wdata    = store_i;
		case (memop_i)
			MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW: begin
				is_load = 1'b1;
			end
			MEM_SB: begin
				is_store = 1'b1;
				wen      = WEN_W'(1) << addr[BOFF_W-1:0];
				wdata    = {4{store_i[7:0]}};	// byte in every lane
			end
			MEM_SH: begin
				is_store = 1'b1;
				wen      = addr[1] ? 4'b1100 : 4'b0011;
				wdata    = {2{store_i[15:0]}};
			end
			MEM_SW: begin
				is_store = 1'b1;
				wen      = '1;
			end
			default: begin
				is_load  = 1'b0;	// MEM_NONE, no access
				is_store = 1'b0;
			end
		endcase
	end

	// kill drops the request but leaves addr and data visible
	always_comb begin
		req_o.en    = (is_load | is_store) & ~kill_i;
		req_o.wen   = kill_i ? '0 : wen;
		req_o.addr  = addr;
		req_o.wdata = wdata;
	end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       stall_i,	// from controller
	input  wire                       flush_i,
	input  wire cpu_pkg::ex_in_t      ex_i,
	input  wire [cpu_pkg::XLEN-1:0]   alu_res_i,
	output cpu_pkg::ex_out_t          ex_o,
	output logic [cpu_pkg::XLEN-1:0]  bypass_o,
	output cpu_pkg::dmem_req_t        dmem_o
);
	import cpu_pkg::*;

	logic              kill;
	logic [BOFF_W-1:0] boff;
	ex_out_t           ex_next;
	ex_out_t           ex_q;

	// a held or squashed instruction must not touch memory
	assign kill = stall_i | flush_i;

	mem_access u_mem_access (
		.memop_i  (ex_i.memop),
		.base_i   (ex_i.opr1),
		.offset_i (ex_i.offset),
		.store_i  (ex_i.opr2),
		.kill_i   (kill),
		.req_o    (dmem_o),
		.boff_o   (boff)
	);

	always_comb begin
		ex_next.wren   = ex_i.wren;
		ex_next.waddr  = ex_i.waddr;
		ex_next.wdata  = alu_res_i;
		ex_next.nofwd  = ex_i.nofwd;
		ex_next.inst   = ex_i.inst;
		ex_next.inslot = ex_i.inslot;
		ex_next.pc     = ex_i.pc;
		ex_next.memop  = ex_i.memop;
		ex_next.boff   = boff;
	end

	// flush beats stall
	always_ff @(posedge clk) begin
		if (rst_i || flush_i) begin
			ex_q <= EX_OUT_EMPTY;
		end else if (!stall_i) begin
			ex_q <= ex_next;
		end
	end

	assign ex_o     = ex_q;
	assign bypass_o = alu_res_i;	// unregistered, for forwarding into id

endmodule

`default_nettype wire

// ==== hdl/ex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_top (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       stall_i,
	input  wire                       flush_i,
	input  wire cpu_pkg::ex_in_t      ex_i,
	output cpu_pkg::ex_out_t          ex_o,
	output logic [cpu_pkg::XLEN-1:0]  bypass_o,
	output cpu_pkg::dmem_req_t        dmem_o
);
	import cpu_pkg::*;

	logic [XLEN-1:0] alu_res;	// alu back into execute

	alu u_alu (
		.aluop_i (ex_i.aluop),
		.opr1_i  (ex_i.opr1),
		.opr2_i  (ex_i.opr2),
		.res_o   (alu_res)
	);

	execute u_execute (
		.clk       (clk),
		.rst_i     (rst_i),
		.stall_i   (stall_i),
		.flush_i   (flush_i),
		.ex_i      (ex_i),
		.alu_res_i (alu_res),
		.ex_o      (ex_o),
		.bypass_o  (bypass_o),
		.dmem_o    (dmem_o)
	);

endmodule

`default_nettype wire

// ==== bench/ex_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       vec_valid_i,
	input  wire                       stall_i,
	input  wire                       flush_i,
	input  wire cpu_pkg::ex_in_t      stim_i,
	input  wire [cpu_pkg::XLEN-1:0]   exp_bypass_i,
	input  wire cpu_pkg::dmem_req_t   exp_dmem_i,
	input  wire [cpu_pkg::XLEN-1:0]   exp_wdata_i,
	input  wire                       exp_wren_i,
	input  wire cpu_pkg::ex_out_t     dut_ex_i,
	input  wire [cpu_pkg::XLEN-1:0]   dut_bypass_i,
	input  wire cpu_pkg::dmem_req_t   dut_dmem_i,
	output int                        err_count_o
);
	import cpu_pkg::*;

	int              errors = 0;
	ex_out_t         exp_q = EX_OUT_EMPTY;	// model of the stage register
	logic            pending = 1'b0;
	logic [XLEN-1:0] prev_wdata = '0;
	logic            prev_wren = 1'b0;

	assign err_count_o = errors;

	task automatic report(input string what, input logic [127:0] got,
			input logic [127:0] exp);
		errors++;
		$display("[ERROR] %0d ns: %s got %0h expected %0h", $time, what, got, exp);
	endtask

	// flush empties, stall holds, else capture
	function automatic ex_out_t next_expected();
		ex_out_t n;
		if (flush_i) begin
			n = EX_OUT_EMPTY;
		end else if (stall_i) begin
			n = exp_q;
		end else begin
			n.wren   = stim_i.wren;
			n.waddr  = stim_i.waddr;
			n.wdata  = exp_bypass_i;
			n.nofwd  = stim_i.nofwd;
			n.inst   = stim_i.inst;
			n.inslot = stim_i.inslot;
			n.pc     = stim_i.pc;
			n.memop  = stim_i.memop;
			n.boff   = exp_dmem_i.addr[BOFF_W-1:0];
		end
		return n;
	endfunction

	always @(posedge clk) begin
		if (rst_i) begin
			exp_q   <= EX_OUT_EMPTY;
			pending <= 1'b1;
			prev_wdata <= '0;
			prev_wren  <= 1'b0;
		end else begin
			// ex_o here still shows what the previous edge stored
			if (pending) begin
				if (dut_ex_i !== exp_q)
					report("ex_o record", 128'(dut_ex_i), 128'(exp_q));
				if (dut_ex_i.wdata !== prev_wdata)
					report("ex_o.wdata", 128'(dut_ex_i.wdata), 128'(prev_wdata));
				if (dut_ex_i.wren !== prev_wren)
					report("ex_o.wren", 128'(dut_ex_i.wren), 128'(prev_wren));
			end
			if (vec_valid_i) begin
				if (dut_bypass_i !== exp_bypass_i)
					report("bypass_o", 128'(dut_bypass_i), 128'(exp_bypass_i));
				if (dut_dmem_i !== exp_dmem_i)
					report("dmem_o", 128'(dut_dmem_i), 128'(exp_dmem_i));
				exp_q      <= next_expected();
				prev_wdata <= exp_wdata_i;
				prev_wren  <= exp_wren_i;
				pending    <= 1'b1;
			end else begin
				pending <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/ex_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_asserts (
	input  wire                       clk,
	input  wire                       rst_i,
	input  wire                       stall_i,
	input  wire                       flush_i,
	input  wire cpu_pkg::ex_out_t     ex_q_i,
	input  wire cpu_pkg::dmem_req_t   dmem_i
);
	import cpu_pkg::*;

	a_reset_empty: assert property (@(posedge clk) rst_i |=> !ex_q_i.wren)
		else $error("ex_o.wren high after a reset cycle");

	a_flush_empty: assert property (@(posedge clk) flush_i |=> !ex_q_i.wren)
		else $error("ex_o.wren high after a flush cycle");

	a_kill_no_req: assert property (@(posedge clk) (stall_i || flush_i) |-> !dmem_i.en)
		else $error("dmem request enabled during stall or flush");

	a_wen_needs_en: assert property (@(posedge clk) (dmem_i.wen != '0) |-> dmem_i.en)
		else $error("dmem write enables set without en");

endmodule

bind execute ex_asserts u_asserts (
	.clk     (clk),
	.rst_i   (rst_i),
	.stall_i (stall_i),
	.flush_i (flush_i),
	.ex_q_i  (ex_o),
	.dmem_i  (dmem_o)
);

`default_nettype wire

// ==== bench/tb_ex_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ex_top;
	import cpu_pkg::*;

	localparam int MAX_VEC   = 64;
	localparam int NUM_COLS  = 20;
	localparam int RST_CYC   = 4;
	localparam int SLACK_CYC = 16;

	logic            clk = 1'b0;
	logic            rst_i;
	logic            stall_i;
	logic            flush_i;
	ex_in_t          ex_i;
	ex_out_t         ex_o;
	logic [XLEN-1:0] bypass_o;
	dmem_req_t       dmem_o;

	logic            vec_valid;
	logic [XLEN-1:0] exp_bypass;
	dmem_req_t       exp_dmem;
	logic [XLEN-1:0] exp_wdata;
	logic            exp_wren;
	int              err_count;

	logic [31:0] vec [0:MAX_VEC-1][0:NUM_COLS-1];
	int          n_vec = 0;
	int          cycles = 0;
	int          cycle_limit = 0;

	always #50 clk = ~clk;

	ex_top u_dut (
		.clk      (clk),
		.rst_i    (rst_i),
		.stall_i  (stall_i),
		.flush_i  (flush_i),
		.ex_i     (ex_i),
		.ex_o     (ex_o),
		.bypass_o (bypass_o),
		.dmem_o   (dmem_o)
	);

	ex_checker u_checker (
		.clk          (clk),
		.rst_i        (rst_i),
		.vec_valid_i  (vec_valid),
		.stall_i      (stall_i),
		.flush_i      (flush_i),
		.stim_i       (ex_i),
		.exp_bypass_i (exp_bypass),
		.exp_dmem_i   (exp_dmem),
		.exp_wdata_i  (exp_wdata),
		.exp_wren_i   (exp_wren),
		.dut_ex_i     (ex_o),
		.dut_bypass_i (bypass_o),
		.dut_dmem_i   (dmem_o),
		.err_count_o  (err_count)
	);

	task automatic load_vectors();
		int          fd;
		int          cnt;
		string       line;
		logic [31:0] f [0:NUM_COLS-1];
		fd = $fopen("bench/ex_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/ex_testdata.txt, no stimulus to run");
		end else begin
			while (!$feof(fd)) begin
				cnt = $fgets(line, fd);
				if (cnt > 0 && line.len() > 0 && line[0] != "#") begin
					cnt = $sscanf(line,
						"%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9],
						f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17],
						f[18], f[19]);
					if (cnt == NUM_COLS && n_vec < MAX_VEC) begin
						for (int c = 0; c < NUM_COLS; c++) begin
							vec[n_vec][c] = f[c];
						end
						n_vec++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// columns follow the order in the data file header
	task automatic drive_vector(input int i);
		stall_i         = vec[i][0][0];
		flush_i         = vec[i][1][0];
		ex_i.aluop      = alu_op_e'(vec[i][2][3:0]);
		ex_i.memop      = mem_op_e'(vec[i][3][3:0]);
		ex_i.opr1       = vec[i][4];
		ex_i.opr2       = vec[i][5];
		ex_i.offset     = vec[i][6];
		ex_i.wren       = vec[i][7][0];
		ex_i.waddr      = vec[i][8][REG_AW-1:0];
		ex_i.inslot     = vec[i][9][0];
		ex_i.nofwd      = vec[i][10][0];
		ex_i.pc         = vec[i][11];
		ex_i.inst       = vec[i][12];
		exp_bypass      = vec[i][13];
		exp_dmem.en     = vec[i][14][0];
		exp_dmem.wen    = vec[i][15][WEN_W-1:0];
		exp_dmem.addr   = vec[i][16];
		exp_dmem.wdata  = vec[i][17];
		exp_wdata       = vec[i][18];
		exp_wren        = vec[i][19][0];
		vec_valid       = 1'b1;
	endtask

	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("ERRORS FOUND");
			$finish;
		end
	end

	initial begin
		rst_i      = 1'b1;
		stall_i    = 1'b0;
		flush_i    = 1'b0;
		ex_i       = '0;
		vec_valid  = 1'b0;
		exp_bypass = '0;
		exp_dmem   = '0;
		exp_wdata  = '0;
		exp_wren   = 1'b0;
		load_vectors();
		cycle_limit = n_vec + RST_CYC + SLACK_CYC;
		repeat (RST_CYC) @(posedge clk);
		@(negedge clk);
		rst_i = 1'b0;
		for (int i = 0; i < n_vec; i++) begin
			if (i > 0) begin
				@(negedge clk);
			end
			drive_vector(i);
		end
		@(negedge clk);
		vec_valid = 1'b0;
		stall_i   = 1'b0;
		flush_i   = 1'b0;
		@(posedge clk);	// last ex_o check
		@(negedge clk);
		$display("run complete, %0d vectors, %0d errors", n_vec, err_count);
		if (err_count == 0 && n_vec > 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== bench/ex_testdata.txt ====
# stall flush aluop memop opr1 opr2 offset wren waddr inslot nofwd pc inst (all hex)
# then expected: bypass dmem_en dmem_wen dmem_addr dmem_wdata ex_o.wdata ex_o.wren
0 0 0 0 00000005 00000007 00000000 1 02 0 0 00400000 00a61020 0000000c 0 0 00000005 00000007 0000000c 1
0 0 1 0 00000005 00000007 00000000 1 03 0 0 00400004 00a61822 fffffffe 0 0 00000005 00000007 fffffffe 1
0 0 2 0 f0f0f0f0 ff00ff00 00000000 1 04 0 0 00400008 00a62024 f000f000 0 0 f0f0f0f0 ff00ff00 f000f000 1
0 0 3 0 f0f0f0f0 ff00ff00 00000000 1 05 0 0 0040000c 00a62825 fff0fff0 0 0 f0f0f0f0 ff00ff00 fff0fff0 1
0 0 4 0 f0f0f0f0 ff00ff00 00000000 1 06 0 0 00400010 00a63026 0ff00ff0 0 0 f0f0f0f0 ff00ff00 0ff00ff0 1
0 0 5 0 0000ffff 00ff0000 00000000 1 07 0 0 00400014 00a63827 ff000000 0 0 0000ffff 00ff0000 ff000000 1
0 0 6 0 80000000 00000001 00000000 1 08 0 0 00400018 00a6402a 00000001 0 0 80000000 00000001 00000001 1
0 0 7 0 80000000 00000001 00000000 1 09 0 0 0040001c 00a6482b 00000000 0 0 80000000 00000001 00000000 1
0 0 6 0 00000001 ffffffff 00000000 1 0a 0 0 00400020 00a6502a 00000000 0 0 00000001 ffffffff 00000000 1
0 0 7 0 00000001 ffffffff 00000000 1 0b 0 0 00400024 00a6582b 00000001 0 0 00000001 ffffffff 00000001 1
0 0 8 0 00000000 12345678 00000000 1 0c 0 0 00400028 00066000 12345678 0 0 00000000 12345678 12345678 1
0 0 8 0 0000001f 00000003 00000000 1 0d 0 0 0040002c 00066fc0 80000000 0 0 0000001f 00000003 80000000 1
0 0 9 0 0000001f 80000000 00000000 1 0e 0 0 00400030 000677c2 00000001 0 0 0000001f 80000000 00000001 1
0 0 a 0 0000001f 80000000 00000000 1 0f 0 0 00400034 00067fc3 ffffffff 0 0 0000001f 80000000 ffffffff 1
0 0 a 0 00000004 f0000000 00000000 1 10 0 0 00400038 00068103 ff000000 0 0 00000004 f0000000 ff000000 1
0 0 b 0 00000000 0000abcd 00000000 1 11 0 0 0040003c 3c11abcd abcd0000 0 0 00000000 0000abcd abcd0000 1
0 0 0 6 00001000 11223344 00000000 0 00 0 0 00400040 a0850000 11224344 1 1 00001000 44444444 11224344 0
0 0 0 6 00001000 11223344 00000001 0 00 0 0 00400044 a0850001 11224344 1 2 00001001 44444444 11224344 0
0 0 0 6 00001000 11223344 00000002 0 00 0 0 00400048 a0850002 11224344 1 4 00001002 44444444 11224344 0
0 0 0 6 00001000 11223344 00000003 0 00 0 0 0040004c a0850003 11224344 1 8 00001003 44444444 11224344 0
0 0 0 7 00001000 11223344 00000000 0 00 0 0 00400050 a4850000 11224344 1 3 00001000 33443344 11224344 0
0 0 0 7 00001000 11223344 00000002 0 00 0 0 00400054 a4850002 11224344 1 c 00001002 33443344 11224344 0
0 0 0 8 00001000 11223344 00000004 0 00 0 0 00400058 ac850004 11224344 1 f 00001004 11223344 11224344 0
0 0 0 5 00001000 11223344 00000008 1 08 0 0 0040005c 8c880008 11224344 1 0 00001008 11223344 11224344 1
0 0 0 2 00001000 11223344 fffffffd 1 09 0 0 00400060 9089fffd 11224344 1 0 00000ffd 11223344 11224344 1
1 0 0 8 00000020 00000030 00000000 1 0a 0 0 00400064 ac8a0000 00000050 0 0 00000020 00000030 11224344 1
1 0 0 5 00000040 00000001 00000000 1 0b 0 0 00400068 8c8b0000 00000041 0 0 00000040 00000001 11224344 1
0 1 0 5 00000001 00000002 00000000 1 0c 0 0 0040006c 8c8c0000 00000003 0 0 00000001 00000002 00000000 0
1 1 0 6 00000003 00000004 00000000 1 0d 0 0 00400070 a08d0000 00000007 0 0 00000003 04040404 00000000 0
0 0 0 3 00000100 00000023 00000002 1 0a 1 0 bfc00010 24080001 00000123 1 0 00000102 00000023 00000123 1
0 0 3 0 00000007 00000010 00000000 1 1f 0 1 bfc00014 34e80010 00000017 0 0 00000007 00000010 00000017 1
0 0 4 1 0000000a 0000000f 00000001 1 01 1 1 bfc00018 01494026 00000005 1 0 0000000b 0000000f 00000005 1

// ==== tb.f ====
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/mem_access.sv
hdl/execute.sv
hdl/ex_top.sv
bench/ex_checker.sv
bench/ex_asserts.sv
bench/tb_ex_top.sv

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module tb_ex_top -o Vtb_ex_top \
	|| { echo "build failed"; exit 1; }
./obj_dir/Vtb_ex_top > sim.log 2>&1 ; cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; } \
	|| grep -q "NO ERRORS" sim.log || { echo "simulation ended without a result"; exit 1; }
